// File: cfg_if.sv
// Register settings from the CSR bank to timing and pixel logic, with frame status back
`timescale 1ns/10ps

interface cfg_if;
  import frame_pkg::*;

  // Driven by the CSR bank
  logic             enable;      // Run frames while set
  pattern_e         pattern;
  logic [COL_W-1:0] num_cols;    // Already clamped to 1..MAX_COLS
  logic [ROW_W-1:0] num_rows;    // Already clamped to 1..MAX_ROWS
  gain_arr_t        gains;

  // Driven by the timing FSM
  logic             frame_done;  // Pulse on last active pixel
  logic             busy;        // FSM not idle

  modport csr (
    output enable, pattern, num_cols, num_rows, gains,
    input  frame_done, busy
  );

  modport timing (
    input  enable, num_cols, num_rows,
    output frame_done, busy
  );

  modport pixel (
    input  pattern, gains
  );

endinterface

// File: frame_counter.sv
// Blanking timer plus column and row position counters driven by the frame timing FSM
`timescale 1ns/10ps

module frame_counter #(
  parameter int BLANK_W = 3  // Must match the timer interface
) (
  input  logic   pixel_clk_i,
  input  logic   arst_n_i,
  cfg_if.timing  cfg,
  timer_if.count tmr
);
  import frame_pkg::*;

  logic [BLANK_W-1:0] blank_cnt;  // Cycles left in the phase
  logic [COL_W-1:0]   cols_q;     // Sizes for the frame in flight
  logic [ROW_W-1:0]   rows_q;

  // ******************************
  // Blanking timer
  // ******************************
  always_ff @(posedge pixel_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      blank_cnt <= '0;
    end else if (tmr.blank_load) begin
      blank_cnt <= tmr.blank_len;
    end else if (blank_cnt != '0) begin
      blank_cnt <= blank_cnt - 1'b1;  // Parks at zero
    end
  end

  assign tmr.blank_done = (blank_cnt == BLANK_W'(1));

  // Size latch, mid-frame writes wait for the next frame
  always_ff @(posedge pixel_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cols_q <= '0;
      rows_q <= '0;
    end else if (tmr.frame_load) begin
      cols_q <= cfg.num_cols;
      rows_q <= cfg.num_rows;
    end
  end

  // ******************************
  // Position
  // ******************************
  always_ff @(posedge pixel_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tmr.col <= '0;
      tmr.row <= '0;
    end else if (tmr.frame_load) begin
      tmr.col <= '0;
      tmr.row <= '0;
    end else if (tmr.active_run) begin
      if (tmr.col_last) begin
        tmr.col <= '0;  // Wrap into next row
        tmr.row <= tmr.row_last ? '0 : tmr.row + 1'b1;
      end else begin
        tmr.col <= tmr.col + 1'b1;
      end
    end
  end

  assign tmr.col_last = (tmr.col == COL_W'(cols_q - 1'b1));
  assign tmr.row_last = (tmr.row == ROW_W'(rows_q - 1'b1));

endmodule

// File: frame_gen_asserts.sv
// Concurrent protocol and timing checks, bound onto the frame generator top level
`timescale 1ns/10ps

module frame_gen_asserts #(
  parameter int V_SYNCH = 2
) (
  input logic pixel_clk_i,
  input logic arst_n_i,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_o,
  input logic pix_valid_o,
  input logic vsync_o
);

  // ******************************
  // Wishbone handshake
  // ******************************
  ack_single: assert property (@(posedge pixel_clk_i) disable iff (!arst_n_i)
    wb_ack_o |=> !wb_ack_o) else $error("ack held longer than one cycle");

  ack_cause: assert property (@(posedge pixel_clk_i) disable iff (!arst_n_i)
    $rose(wb_ack_o) |-> $past(wb_cyc_i && wb_stb_i))  // No ack without a request
    else $error("ack without cyc and stb");

  // ******************************
  // Frame timing
  // ******************************
  vsync_len: assert property (@(posedge pixel_clk_i) disable iff (!arst_n_i)
    $rose(vsync_o) |-> vsync_o [*V_SYNCH] ##1 !vsync_o)
    else $error("vsync pulse length wrong");

  no_pix_in_sync: assert property (@(posedge pixel_clk_i) disable iff (!arst_n_i)
    !(pix_valid_o && vsync_o)) else $error("pixel during vsync");

endmodule

bind frame_gen_top frame_gen_asserts #(.V_SYNCH(V_SYNCH)) asserts_i (
  .pixel_clk_i(pixel_clk_i),
  .arst_n_i   (arst_n_i   ),
  .wb_cyc_i   (wb_cyc_i   ),
  .wb_stb_i   (wb_stb_i   ),
  .wb_ack_o   (wb_ack_o   ),
  .pix_valid_o(pix_valid_o),
  .vsync_o    (vsync_o    )
);

// File: frame_gen_top.sv
// Top level of the test pattern frame generator with its Wishbone register port
`timescale 1ns/10ps

module frame_gen_top #(
  parameter int F_PORCH      = 2,
  parameter int V_SYNCH      = 2,
  parameter int V_BACK_PORCH = 4
) (
  input  logic                             pixel_clk_i,
  input  logic                             arst_n_i,
  // Wishbone classic slave
  input  logic                             wb_cyc_i,
  input  logic                             wb_stb_i,
  input  logic                             wb_we_i,
  input  logic [frame_pkg::WB_ADR_W-1:0]   wb_adr_i,
  input  logic [frame_pkg::WB_DAT_W/8-1:0] wb_sel_i,
  input  logic [frame_pkg::WB_DAT_W-1:0]   wb_dat_i,
  output logic [frame_pkg::WB_DAT_W-1:0]   wb_dat_o,
  output logic                             wb_ack_o,
  // Pixel stream, free running
  output logic                             pix_valid_o,
  output frame_pkg::pixel_t                pix_data_o,
  output logic                             frame_start_o,
  output logic                             line_start_o,
  output logic                             vsync_o
);

  // Timer sized for the longest blanking phase
  localparam int MAX_BLANK = (F_PORCH > V_SYNCH) ?
                             ((F_PORCH > V_BACK_PORCH) ? F_PORCH : V_BACK_PORCH) :
                             ((V_SYNCH > V_BACK_PORCH) ? V_SYNCH : V_BACK_PORCH);
  localparam int BLANK_W   = $clog2(MAX_BLANK + 1);

  cfg_if                        cfg ();
  timer_if #(.BLANK_W(BLANK_W)) tmr ();

  // ******************************
  // Register bank
  // ******************************
  wb_csr_bank csr_bank_i (
    .pixel_clk_i(pixel_clk_i),
    .arst_n_i   (arst_n_i   ),
    .wb_cyc_i   (wb_cyc_i   ),
    .wb_stb_i   (wb_stb_i   ),
    .wb_we_i    (wb_we_i    ),
    .wb_adr_i   (wb_adr_i   ),
    .wb_sel_i   (wb_sel_i   ),
    .wb_dat_i   (wb_dat_i   ),
    .wb_dat_o   (wb_dat_o   ),
    .wb_ack_o   (wb_ack_o   ),
    .cfg        (cfg        )
  );

  // ******************************
  // Timing and pixel path
  // ******************************
  frame_timing_fsm #(
    .F_PORCH     (F_PORCH     ),
    .V_SYNCH     (V_SYNCH     ),
    .V_BACK_PORCH(V_BACK_PORCH),
    .BLANK_W     (BLANK_W     )
  ) timing_fsm_i (
    .pixel_clk_i(pixel_clk_i),
    .arst_n_i   (arst_n_i   ),
    .cfg        (cfg        ),
    .tmr        (tmr        ),
    .vsync_o    (vsync_o    )
  );

  frame_counter #(
    .BLANK_W(BLANK_W)
  ) counter_i (
    .pixel_clk_i(pixel_clk_i),
    .arst_n_i   (arst_n_i   ),
    .cfg        (cfg        ),
    .tmr        (tmr        )
  );

  pattern_gain pattern_gain_i (
    .pixel_clk_i  (pixel_clk_i  ),
    .arst_n_i     (arst_n_i     ),
    .cfg          (cfg          ),
    .tmr          (tmr          ),
    .pix_valid_o  (pix_valid_o  ),
    .pix_data_o   (pix_data_o   ),
    .frame_start_o(frame_start_o),
    .line_start_o (line_start_o )
  );

endmodule

// File: frame_pkg.sv
// Shared widths, register map and state types for the test pattern frame generator
package frame_pkg;

  // ******************************
  // Widths and limits
  // ******************************
  localparam int PIXEL_BITS = 10;   // Pixel word width
  localparam int MAX_COLS   = 64;   // Largest frame width
  localparam int MAX_ROWS   = 64;   // Largest frame height
  localparam int COL_W      = 7;    // Holds 0..64
  localparam int ROW_W      = 7;
  localparam int WB_DAT_W   = 32;   // Wishbone data
  localparam int WB_ADR_W   = 8;    // Byte address
  localparam int GAIN_BITS  = 8;    // Unsigned 4.4
  localparam int GAIN_FRAC  = 4;
  localparam int NUM_CHAN   = 4;    // Bayer channels

  typedef logic [PIXEL_BITS-1:0] pixel_t;
  typedef logic [GAIN_BITS-1:0]  gain_t;
  typedef gain_t [NUM_CHAN-1:0]  gain_arr_t;  // Channel n sits in byte n

  // Pattern select, CTRL bit 1
  typedef enum logic {
    PAT_RAMP = 1'b0,  // Pixel is the column
    PAT_DIAG = 1'b1   // Pixel is column plus row
  } pattern_e;

  // Register map in 32-bit words
  typedef enum logic [WB_ADR_W-3:0] {
    CSR_CTRL   = 'd0,  // Bit 0 enable, bit 1 pattern
    CSR_COLS   = 'd1,
    CSR_ROWS   = 'd2,
    CSR_GAIN   = 'd3,  // Channel n in byte n
    CSR_FRAMES = 'd4,  // Read only
    CSR_STATUS = 'd5   // Bit 0 busy, read only
  } csr_addr_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_F_PORCH,
    ST_V_SYNCH,
    ST_V_BACK,
    ST_ACTIVE
  } frame_state_e;

endpackage

// File: frame_timing_fsm.sv
// Frame sequencer stepping through front porch, vertical sync, back porch and active lines
`timescale 1ns/10ps

module frame_timing_fsm #(
  parameter int F_PORCH      = 2,
  parameter int V_SYNCH      = 2,
  parameter int V_BACK_PORCH = 4,
  parameter int BLANK_W      = 3   // Timer width, from the top level
) (
  input  logic  pixel_clk_i,
  input  logic  arst_n_i,
  cfg_if.timing cfg,
  timer_if.ctrl tmr,
  output logic  vsync_o
);
  import frame_pkg::*;

  frame_state_e state;
  frame_state_e state_nxt;
  logic         frame_end;  // Last active pixel

  assign frame_end = (state == ST_ACTIVE) && tmr.col_last && tmr.row_last;

  // ******************************
  // Next state and timer loads
  // ******************************
  always_comb begin
    state_nxt      = state;
    tmr.blank_load = 1'b0;
    tmr.blank_len  = '0;
    tmr.frame_load = 1'b0;
    case (state)
      ST_IDLE: begin
        if (cfg.enable) begin
          state_nxt      = ST_F_PORCH;
          tmr.blank_load = 1'b1;
          tmr.blank_len  = BLANK_W'(F_PORCH);
          tmr.frame_load = 1'b1;  // Sample sizes at frame start
        end
      end
      ST_F_PORCH: begin
        if (tmr.blank_done) begin
          state_nxt      = ST_V_SYNCH;
          tmr.blank_load = 1'b1;
          tmr.blank_len  = BLANK_W'(V_SYNCH);
        end
      end
      ST_V_SYNCH: begin
        if (tmr.blank_done) begin
          state_nxt      = ST_V_BACK;
          tmr.blank_load = 1'b1;
          tmr.blank_len  = BLANK_W'(V_BACK_PORCH);
        end
      end
      ST_V_BACK: begin
        if (tmr.blank_done) begin
          state_nxt = ST_ACTIVE;  // Position already cleared
        end
      end
      ST_ACTIVE: begin
        if (frame_end) begin
          // Frame always completes, enable only decides what follows
          if (cfg.enable) begin
            state_nxt      = ST_F_PORCH;
            tmr.blank_load = 1'b1;
            tmr.blank_len  = BLANK_W'(F_PORCH);
            tmr.frame_load = 1'b1;
          end else begin
            state_nxt = ST_IDLE;
          end
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge pixel_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign tmr.active_run = (state == ST_ACTIVE);
  assign cfg.frame_done = frame_end;
  assign cfg.busy       = (state != ST_IDLE);
  assign vsync_o        = (state == ST_V_SYNCH);  // Straight from the state flop

endmodule

// File: pattern_gain.sv
// Test pattern pixel source with per-Bayer-channel 4.4 gain, saturation and frame markers
`timescale 1ns/10ps

module pattern_gain (
  input  logic              pixel_clk_i,
  input  logic              arst_n_i,
  cfg_if.pixel              cfg,
  timer_if.count            tmr,
  output logic              pix_valid_o,
  output frame_pkg::pixel_t pix_data_o,
  output logic              frame_start_o,
  output logic              line_start_o
);
  import frame_pkg::*;

  localparam int PROD_W  = PIXEL_BITS + GAIN_BITS;
  localparam int SCALE_W = PROD_W - GAIN_FRAC;

  logic [$clog2(NUM_CHAN)-1:0] chan;     // Bayer cell of this pixel
  pixel_t                      raw;
  gain_t                       gain_sel;
  logic [PROD_W-1:0]           product;
  logic [SCALE_W-1:0]          scaled;   // Fraction bits dropped
  pixel_t                      pix_sat;

  // ******************************
  // Pattern and gain
  // ******************************
  assign chan = {tmr.row[0], tmr.col[0]};  // Row parity picks the pair

  always_comb begin
    if (cfg.pattern == PAT_RAMP) begin
      raw = PIXEL_BITS'(tmr.col);
    end else begin
      raw = PIXEL_BITS'(tmr.col) + PIXEL_BITS'(tmr.row);  // Diagonal
    end
  end

  assign gain_sel = cfg.gains[chan];
  assign product  = PROD_W'(raw) * PROD_W'(gain_sel);
  assign scaled   = product[PROD_W-1:GAIN_FRAC];

  // Clip to full scale when any upper bit is set
  assign pix_sat = (|scaled[SCALE_W-1:PIXEL_BITS]) ? '1 : scaled[PIXEL_BITS-1:0];

  // ******************************
  // Output stage, one cycle behind the position
  // ******************************
  always_ff @(posedge pixel_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pix_valid_o   <= 1'b0;
      frame_start_o <= 1'b0;
      line_start_o  <= 1'b0;
    end else begin
      pix_valid_o   <= tmr.active_run;
      frame_start_o <= tmr.active_run && (tmr.col == '0) && (tmr.row == '0);
      line_start_o  <= tmr.active_run && (tmr.col == '0);  // Every column 0
    end
  end

  always_ff @(posedge pixel_clk_i) begin
    pix_data_o <= pix_sat;
  end

endmodule

// File: run_sim.sh
#!/bin/bash
# Build and run the frame generator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_frame_gen -o sim_frame_gen
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_frame_gen > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" sim.log; then
  exit 1
fi
if ! grep -q "all tests passed" sim.log; then
  echo "no pass line in log"
  exit 1
fi
exit 0

// File: sim.f
frame_pkg.sv
cfg_if.sv
timer_if.sv
wb_csr_bank.sv
frame_timing_fsm.sv
frame_counter.sv
pattern_gain.sv
frame_gen_top.sv
frame_gen_asserts.sv
tb_frame_gen.sv

// File: tb_frame_gen.sv
// Testbench for the frame generator: register traffic, random patterns and a pixel model
`timescale 1ns/10ps

module tb_frame_gen;
  import frame_pkg::*;

  localparam int V_BACK_PORCH = 4;
  localparam int TIMEOUT      = 12 * (8 + MAX_COLS * MAX_ROWS) + 2000;

  logic clk, arst_n, cyc, stb, we, ack;
  logic [WB_ADR_W-1:0] adr;
  logic [3:0] sel;
  logic [31:0] dat_w, dat_r;
  logic pix_valid, frame_start, line_start, vsync;
  pixel_t pix_data;

  int seed = 32'h2132529e;
  int errors = 0;
  int cycles = 0;
  int clips = 0;  // Pixels expected at full scale
  // Register shadows
  logic sh_en, sh_pat;
  logic [31:0] sh_cols, sh_rows;
  logic [7:0] sh_gain [4];
  // Frame position model
  int f_cols, f_rows, col, row, lines, frames_seen, since_vs;
  logic in_frame, vs_seen, vs_prev, stopped;

  frame_gen_top frame_gen_top_i (
    .pixel_clk_i(clk), .arst_n_i(arst_n),
    .wb_cyc_i(cyc), .wb_stb_i(stb), .wb_we_i(we), .wb_adr_i(adr), .wb_sel_i(sel),
    .wb_dat_i(dat_w), .wb_dat_o(dat_r), .wb_ack_o(ack),
    .pix_valid_o(pix_valid), .pix_data_o(pix_data), .frame_start_o(frame_start),
    .line_start_o(line_start), .vsync_o(vsync)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT) begin
      $display("run stopped, no progress within %0d cycles, %0d errors", TIMEOUT, errors);
      $display("tests failed");
      $finish;
    end
  end

  function automatic logic [31:0] clamp(input logic [31:0] v, input int max_v);
    if (v == 0) begin
      return 1;
    end
    if (v > max_v) begin
      return max_v;
    end
    return v;
  endfunction

  function automatic logic [31:0] merge(input logic [31:0] cur, input logic [31:0] d,
                                        input logic [3:0] s);
    logic [31:0] res;
    res = cur;
    for (int i = 0; i < 4; i++) begin
      if (s[i]) begin
        res[8*i +: 8] = d[8*i +: 8];
      end
    end
    return res;
  endfunction

  // Gain rule, 4.4 unsigned, clipped at full scale
  function automatic int expect_pixel(input int c, r);
    int raw, p;
    raw = sh_pat ? c + r : c;
    p = (raw * sh_gain[(r % 2) * 2 + (c % 2)]) >> GAIN_FRAC;
    return (p > 1023) ? 1023 : p;
  endfunction

  function automatic logic [31:0] expect_reg(input int word);
    case (word)
      0: return {30'b0, sh_pat, sh_en};
      1: return sh_cols;
      2: return sh_rows;
      3: return {sh_gain[3], sh_gain[2], sh_gain[1], sh_gain[0]};
      default: return 0;  // Frames, status and holes handled by caller
    endcase
  endfunction

  // ******************************
  // Wishbone master
  // ******************************
  task automatic bus_cycle(input logic w, input int word, input logic [31:0] d,
                           input logic [3:0] s, output logic [31:0] rd);
    int n;
    n = 0;
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= w;
    adr   <= WB_ADR_W'(word << 2);
    dat_w <= d;
    sel   <= s;
    do begin
      @(negedge clk);
      n++;
    end while (!ack && n < 16);
    assert (ack) else begin
      errors++;
      $display("no ack from word address %0d", word);
    end
    rd = dat_r;  // Valid while ack is high
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic csr_write(input int word, input logic [31:0] d, input logic [3:0] s);
    logic [31:0] rd;
    bus_cycle(1'b1, word, d, s, rd);
    case (word)
      0: begin
        if (s[0]) begin
          {sh_pat, sh_en} = d[1:0];
        end
      end
      1: sh_cols = clamp(merge(sh_cols, d, s), MAX_COLS);
      2: sh_rows = clamp(merge(sh_rows, d, s), MAX_ROWS);
      3: begin
        for (int i = 0; i < 4; i++) begin
          if (s[i]) begin
            sh_gain[i] = d[8*i +: 8];
          end
        end
      end
      default: ;
    endcase
  endtask

  task automatic csr_check(input int word, input logic [31:0] exp, input string name);
    logic [31:0] rd;
    bus_cycle(1'b0, word, 32'h0, 4'hf, rd);
    assert (rd == exp) else begin
      errors++;
      $display("error wb_dat_o %h expected %h, %s at word %0d", rd, exp, name, word);
    end
  endtask

  // ******************************
  // Pixel stream model
  // ******************************
  task automatic check_pixel();
    int exp;
    if (frame_start) begin
      assert (!in_frame) else begin
        errors++;
        $display("frame restarted before its end");
      end
      assert (vs_seen) else begin
        errors++;
        $display("frame not preceded by vsync");
      end
      assert (!stopped) else begin
        errors++;
        $display("pixels after the stream stopped");
      end
      assert (since_vs == V_BACK_PORCH + 1) else begin
        errors++;
        $display("error frame_start_o delay %h expected %h", since_vs, V_BACK_PORCH + 1);
      end
      in_frame = 1'b1;
      vs_seen  = 1'b0;
      col      = 0;
      row      = 0;
      lines    = 0;
    end
    assert (in_frame) else begin
      errors++;
      $display("valid pixel outside a frame");
    end
    if (in_frame) begin
      exp = expect_pixel(col, row);
      if (exp == 1023) begin
        clips++;  // Saturated pixel seen
      end
      assert (line_start == (col == 0)) else begin
        errors++;
        $display("error line_start_o %h expected %h", line_start, col == 0);
      end
      assert (pix_data == exp) else begin
        errors++;
        $display("error pix_data_o %h expected %h col %0d row %0d", pix_data, exp, col, row);
      end
      if (line_start) begin
        lines++;
      end
      if (col == f_cols - 1) begin
        col = 0;
        if (row == f_rows - 1) begin  // Last pixel of the frame
          assert (lines == f_rows) else begin
            errors++;
            $display("error line_start_o count %h expected %h", lines, f_rows);
          end
          frames_seen++;
          in_frame = 1'b0;
        end else begin
          row++;
        end
      end else begin
        col++;
      end
    end
  endtask

  always @(negedge clk) begin
    if (arst_n) begin
      if (vsync && !vs_prev) begin  // Sizes latched at frame start
        f_cols  = sh_cols;
        f_rows  = sh_rows;
        vs_seen = 1'b1;
      end
      if (!vsync && vs_prev) begin
        since_vs = 0;
      end else begin
        since_vs++;
      end
      vs_prev = vsync;
      if (pix_valid) begin
        check_pixel();
      end else begin
        assert (!frame_start && !line_start) else begin
          errors++;
          $display("frame or line marker without a valid pixel");
        end
      end
    end
  end

  task automatic wait_frames(input int n);
    int target;
    target = frames_seen + n;
    while (frames_seen < target) @(negedge clk);
  endtask

  // Clear enable, let the frame finish and compare the frame count
  task automatic stop_stream();
    logic [31:0] rd;
    int n;
    n = 0;
    csr_write(0, {30'b0, sh_pat, 1'b0}, 4'h1);
    do begin
      bus_cycle(1'b0, 5, 32'h0, 4'hf, rd);
      n++;
    end while (rd[0] && n < 3000);
    assert (!rd[0]) else begin
      errors++;
      $display("busy never cleared after stop");
    end
    repeat (4) @(negedge clk);
    assert (!in_frame) else begin
      errors++;
      $display("frame left unfinished at stop");
    end
    stopped = 1'b1;
    repeat (40) @(negedge clk);
    csr_check(4, frames_seen, "CSR_FRAMES");
    stopped = 1'b0;
  endtask

  initial begin
    logic [31:0] d;
    int w;
    cyc    = 0;
    stb    = 0;
    we     = 0;
    adr    = 0;
    sel    = 0;
    dat_w  = 0;
    arst_n = 1'b0;
    sh_en   = 0;
    sh_pat  = 0;
    sh_cols = 8;
    sh_rows = 4;
    for (int i = 0; i < 4; i++) begin
      sh_gain[i] = 8'h10;
    end
    f_cols      = 8;
    f_rows      = 4;
    frames_seen = 0;
    since_vs    = 0;
    in_frame    = 0;
    vs_seen     = 0;
    vs_prev     = 0;
    stopped     = 0;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;

    // Reset values and register readback
    for (int i = 0; i < 4; i++) begin
      csr_check(i, expect_reg(i), "reset value");
    end
    csr_check(4, 0, "CSR_FRAMES");
    csr_check(5, 0, "CSR_STATUS");
    repeat (24) begin
      w = $random(seed) & 3;
      d = $random(seed);
      if (w == 0) begin
        d[0] = 1'b0;  // Keep the stream off
      end
      csr_write(w, d, 4'($random(seed) & 15));
      csr_check(w, expect_reg(w), "register readback");
    end
    csr_write(4, $random(seed), 4'hf);
    csr_write(5, $random(seed), 4'hf);
    w = 6 + ($random(seed) & 31);
    csr_write(w, $random(seed), 4'hf);
    csr_check(4, 0, "CSR_FRAMES");
    csr_check(5, 0, "CSR_STATUS");
    csr_check(w, 0, "unmapped word");
    for (int i = 0; i < 4; i++) begin
      csr_check(i, expect_reg(i), "register after ignored write");
    end

    // Ramp with random gains and size
    csr_write(1, 1 + ($random(seed) & 63), 4'hf);
    csr_write(2, 1 + ($random(seed) & 63), 4'hf);
    csr_write(3, $random(seed), 4'hf);
    csr_write(0, 32'h1, 4'h1);
    wait_frames(2);
    stop_stream();

    // Diagonal with large gains and large frames, so the far corner clips
    csr_write(1, 48 + ($random(seed) & 15), 4'hf);
    csr_write(2, 48 + ($random(seed) & 15), 4'hf);
    csr_write(3, $random(seed) | 32'hc0c0c0c0, 4'hf);
    clips = 0;
    csr_write(0, 32'h3, 4'h1);
    wait_frames(2);
    stop_stream();
    assert (clips > 0) else begin
      errors++;
      $display("diagonal frames produced no saturated pixel");
    end

    // Size written mid-frame applies next frame
    csr_write(1, 16 + ($random(seed) & 31), 4'hf);
    csr_write(2, 4 + ($random(seed) & 3), 4'hf);
    csr_write(0, 32'h1, 4'h1);
    while (!in_frame) @(negedge clk);
    csr_write(1, 1 + ($random(seed) & 63), 4'hf);
    csr_write(2, 1 + ($random(seed) & 63), 4'hf);
    wait_frames(3);
    stop_stream();

    $display("checks done, %0d errors in %0d frames", errors, frames_seen);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: timer_if.sv
// Control and position signals between the frame timing FSM and the frame counter
`timescale 1ns/10ps

interface timer_if #(
  parameter int BLANK_W = 8  // Wide enough for the longest blanking phase
);

  // FSM side
  logic                          blank_load;  // Load blank_len into the timer
  logic [BLANK_W-1:0]            blank_len;
  logic                          frame_load;  // Latch sizes, clear position
  logic                          active_run;  // Step position this cycle

  // Counter side
  logic                          blank_done;  // Last cycle of a blanking phase
  logic [frame_pkg::COL_W-1:0]   col;
  logic [frame_pkg::ROW_W-1:0]   row;
  logic                          col_last;
  logic                          row_last;

  modport ctrl (
    output blank_load, blank_len, frame_load, active_run,
    input  blank_done, col_last, row_last
  );

  // Also used read-only by the pixel path
  modport count (
    input  blank_load, blank_len, frame_load, active_run,
    output blank_done, col, row, col_last, row_last
  );

endinterface

// File: wb_csr_bank.sv
// Wishbone classic slave holding the pattern generator control, size, gain and status registers
`timescale 1ns/10ps

module wb_csr_bank (
  input  logic                            pixel_clk_i,
  input  logic                            arst_n_i,
  input  logic                            wb_cyc_i,
  input  logic                            wb_stb_i,
  input  logic                            wb_we_i,
  input  logic [frame_pkg::WB_ADR_W-1:0]  wb_adr_i,
  input  logic [frame_pkg::WB_DAT_W/8-1:0] wb_sel_i,
  input  logic [frame_pkg::WB_DAT_W-1:0]  wb_dat_i,
  output logic [frame_pkg::WB_DAT_W-1:0]  wb_dat_o,
  output logic                            wb_ack_o,
  cfg_if.csr                              cfg
);
  import frame_pkg::*;

  localparam int SEL_W = WB_DAT_W / 8;

  logic                req;       // New transfer this cycle
  csr_addr_e           adr_word;  // Word address
  logic [WB_DAT_W-1:0] frames_q;  // Completed frames
  logic [WB_DAT_W-1:0] rd_data;
  logic [WB_DAT_W-1:0] cols_wr;   // Merged and clamped size writes
  logic [WB_DAT_W-1:0] rows_wr;

  // Byte lane merge of a write into the current value
  function automatic logic [WB_DAT_W-1:0] merge_lanes(
    input logic [WB_DAT_W-1:0] cur,
    input logic [WB_DAT_W-1:0] dat,
    input logic [SEL_W-1:0]    sel
  );
    logic [WB_DAT_W-1:0] res;
    res = cur;
    for (int i = 0; i < SEL_W; i++) begin
      if (sel[i]) begin
        res[8*i +: 8] = dat[8*i +: 8];
      end
    end
    return res;
  endfunction

  // Sizes live in 1..max_val
  function automatic logic [WB_DAT_W-1:0] clamp_size(
    input logic [WB_DAT_W-1:0] val,
    input int                  max_val
  );
    if (val == '0) begin
      return WB_DAT_W'(1);
    end else if (val > WB_DAT_W'(max_val)) begin
      return WB_DAT_W'(max_val);
    end
    return val;
  endfunction

  assign req      = wb_cyc_i & wb_stb_i & ~wb_ack_o;  // Ack drops the request
  assign adr_word = csr_addr_e'(wb_adr_i[WB_ADR_W-1:2]);
  assign cols_wr  = clamp_size(merge_lanes(WB_DAT_W'(cfg.num_cols), wb_dat_i, wb_sel_i), MAX_COLS);
  assign rows_wr  = clamp_size(merge_lanes(WB_DAT_W'(cfg.num_rows), wb_dat_i, wb_sel_i), MAX_ROWS);

  // ******************************
  // Register writes
  // ******************************
  always_ff @(posedge pixel_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg.enable   <= 1'b0;
      cfg.pattern  <= PAT_RAMP;
      cfg.num_cols <= COL_W'(8);
      cfg.num_rows <= ROW_W'(4);
      cfg.gains    <= {NUM_CHAN{GAIN_BITS'(8'h10)}};  // Unity gain
    end else if (req && wb_we_i) begin
      case (adr_word)
        CSR_CTRL: begin
          if (wb_sel_i[0]) begin
            cfg.enable  <= wb_dat_i[0];
            cfg.pattern <= pattern_e'(wb_dat_i[1]);
          end
        end
        CSR_COLS: cfg.num_cols <= COL_W'(cols_wr);
        CSR_ROWS: cfg.num_rows <= ROW_W'(rows_wr);
        CSR_GAIN: begin
          for (int n = 0; n < NUM_CHAN; n++) begin
            if (wb_sel_i[n]) begin
              cfg.gains[n] <= wb_dat_i[8*n +: GAIN_BITS];
            end
          end
        end
        default: ;  // Read-only and unmapped words
      endcase
    end
  end

  // Frame counter, one per completed frame
  always_ff @(posedge pixel_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      frames_q <= '0;
    end else if (cfg.frame_done) begin
      frames_q <= frames_q + 1'b1;
    end
  end

  // ******************************
  // Read path
  // ******************************
  always_comb begin
    rd_data = '0;  // Unmapped reads as zero
    case (adr_word)
      CSR_CTRL:   rd_data = WB_DAT_W'({cfg.pattern, cfg.enable});
      CSR_COLS:   rd_data = WB_DAT_W'(cfg.num_cols);
      CSR_ROWS:   rd_data = WB_DAT_W'(cfg.num_rows);
      CSR_GAIN:   rd_data = WB_DAT_W'(cfg.gains);
      CSR_FRAMES: rd_data = frames_q;
      CSR_STATUS: rd_data = WB_DAT_W'(cfg.busy);
      default:    rd_data = '0;
    endcase
  end

  always_ff @(posedge pixel_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= req;  // Single cycle ack
    end
  end

  // Data held while ack is high
  always_ff @(posedge pixel_clk_i) begin
    if (req) begin
      wb_dat_o <= rd_data;
    end
  end

endmodule
